//--- include/rx_macros.svh
`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

// time-interleaved adc slices, one lane each
`define NTI 16

// adc magnitude width, also the signed code width
`define NADC 8

// prbs order, sets the depth of the generator and checker history
`define NPRBS 7

// width of the error and total bit counters
`define NCOUNT 32

`endif

//--- design/rx_pkg.sv
`default_nettype none

`include "rx_macros.svh"

package rx_pkg;

    // unsigned magnitude of one adc slice
    typedef logic [`NADC-1:0] adc_mag_t;

    // unfolded code, also used for offset and threshold
    typedef logic signed [`NADC-1:0] adc_code_t;

    // one bit per lane, lane 0 is the oldest bit of the word
    typedef logic [`NTI-1:0] lane_bits_t;

    // last NPRBS bits of the stream, bit 0 is the oldest
    typedef logic [`NPRBS-1:0] prbs_hist_t;

    typedef logic [`NCOUNT-1:0] bit_count_t;

endpackage

`default_nettype wire

//--- design/prbs_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface prbs_ctrl_if;
    import rx_pkg::*;

    // 1 feeds the checker from the generator, 0 from the adc slicer
    logic       sel_bist;
    // one-cycle pulse, flips one generated bit
    logic       gen_inj_err;
    // checker enable level
    logic       prbs_cke;
    lane_bits_t chan_sel;
    lane_bits_t inv_chicken;

    modport gen (
        input gen_inj_err
    );

    modport sel (
        input sel_bist
    );

    modport chk (
        input prbs_cke,
        input chan_sel,
        input inv_chicken
    );

endinterface

`default_nettype wire

//--- design/adc_unfolder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_macros.svh"

module adc_unfolder (
    input  wire logic             clk_adc,
    input  wire logic             rst_i,
    input  wire rx_pkg::adc_mag_t adc_mag_i [`NTI-1:0],
    input  wire rx_pkg::lane_bits_t adc_sign_i,
    input  wire rx_pkg::adc_code_t pfd_offset_i,
    output rx_pkg::adc_code_t     code_o [`NTI-1:0]
);
    import rx_pkg::*;

    // two guard bits cover +-magnitude minus the offset
    localparam int ext_w = `NADC + 2;
    localparam logic signed [ext_w-1:0] code_max = ext_w'((2 ** (`NADC - 1)) - 1);
    localparam logic signed [ext_w-1:0] code_min = ext_w'(-(2 ** (`NADC - 1)));

    logic signed [ext_w-1:0] folded [`NTI-1:0];
    logic signed [ext_w-1:0] diff [`NTI-1:0];

    function automatic adc_code_t saturate(input logic signed [ext_w-1:0] v);
        logic signed [ext_w-1:0] c;
        if (v > code_max) begin
            c = code_max;
        end else if (v < code_min) begin
            c = code_min;
        end else begin
            c = v;
        end
        return adc_code_t'(c);
    endfunction

    // sign 1 is the positive half, sign 0 the negative one
    always_comb begin
        for (int k = 0; k < `NTI; k++) begin
            folded[k] = $signed({2'b00, adc_mag_i[k]});
            if (!adc_sign_i[k]) begin
                folded[k] = -folded[k];
            end
            diff[k] = folded[k] - ext_w'(pfd_offset_i);
        end
    end

    always_ff @(posedge clk_adc) begin
        for (int k = 0; k < `NTI; k++) begin
            if (rst_i) begin
                code_o[k] <= '0;
            end else begin
                code_o[k] <= saturate(diff[k]);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/bit_decision.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_macros.svh"

module bit_decision (
    input  wire logic               clk_adc,
    input  wire logic               rst_i,
    input  wire rx_pkg::adc_code_t  code_i [`NTI-1:0],
    input  wire rx_pkg::adc_code_t  thresh_i,
    input  wire rx_pkg::lane_bits_t bist_bits_i,
    prbs_ctrl_if.sel                ctrl,
    output rx_pkg::lane_bits_t      rx_bits_o
);
    import rx_pkg::*;

    lane_bits_t sliced_d;
    lane_bits_t sliced_q;

    // signed compare, a code equal to the threshold slices to 0
    always_comb begin
        for (int k = 0; k < `NTI; k++) begin
            sliced_d[k] = (code_i[k] > thresh_i);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            sliced_q <= '0;
        end else begin
            sliced_q <= sliced_d;
        end
    end

    // source mux is not registered, the checker retimes it
    assign rx_bits_o = ctrl.sel_bist ? bist_bits_i : sliced_q;

endmodule

`default_nettype wire

//--- design/prbs_bist_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_macros.svh"

module prbs_bist_gen (
    input  wire logic          clk_adc,
    input  wire logic          rst_i,
    prbs_ctrl_if.gen           ctrl,
    output rx_pkg::lane_bits_t bits_o
);
    import rx_pkg::*;

    prbs_hist_t                   hist_q;
    lane_bits_t                   word;
    lane_bits_t                   bits_q;
    logic [`NPRBS+`NTI-1:0]       stream;

    // stream[0] is seven bits back from lane 0
    // b[n] = b[n-7] ^ b[n-6], unrolled over all lanes
    always_comb begin
        stream = '0;
        stream[`NPRBS-1:0] = hist_q;
        for (int k = 0; k < `NTI; k++) begin
            stream[`NPRBS+k] = stream[k] ^ stream[k+1];
        end
        word = stream[`NPRBS+`NTI-1:`NPRBS];
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist_q <= '1;
            bits_q <= '0;
        end else begin
            // newest seven lanes seed the next word
            hist_q <= word[`NTI-1 -: `NPRBS];
            // injected error only hits the output copy
            bits_q <= word ^ lane_bits_t'(ctrl.gen_inj_err);
        end
    end

    assign bits_o = bits_q;

endmodule

`default_nettype wire

//--- design/prbs_err_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_macros.svh"

module prbs_err_checker (
    input  wire logic               clk_adc,
    input  wire logic               rst_i,
    input  wire rx_pkg::lane_bits_t rx_bits_i,
    prbs_ctrl_if.chk                ctrl,
    output rx_pkg::bit_count_t      err_count_o,
    output rx_pkg::bit_count_t      total_count_o
);
    import rx_pkg::*;

    localparam int pop_w = $clog2(`NTI + 1);

    prbs_hist_t             hist_q;
    logic                   primed_q;
    bit_count_t             err_q;
    bit_count_t             total_q;
    lane_bits_t             rx_inv;
    lane_bits_t             pred;
    lane_bits_t             err_lanes;
    logic [`NPRBS+`NTI-1:0] stream;

    function automatic logic [pop_w-1:0] popcount(input lane_bits_t v);
        logic [pop_w-1:0] n;
        n = '0;
        for (int i = 0; i < `NTI; i++) begin
            n = n + pop_w'(v[i]);
        end
        return n;
    endfunction

    // self-synchronizing, the prediction uses received bits only
    always_comb begin
        rx_inv = rx_bits_i ^ ctrl.inv_chicken;
        stream = {rx_inv, hist_q};
        for (int k = 0; k < `NTI; k++) begin
            pred[k] = stream[k] ^ stream[k+1];
        end
        err_lanes = (pred ^ rx_inv) & ctrl.chan_sel;
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            hist_q   <= '0;
            primed_q <= 1'b0;
            err_q    <= '0;
            total_q  <= '0;
        end else if (ctrl.prbs_cke) begin
            hist_q   <= rx_inv[`NTI-1 -: `NPRBS];
            primed_q <= 1'b1;
            // first enabled word only fills the history
            if (primed_q) begin
                err_q   <= err_q + bit_count_t'(popcount(err_lanes));
                total_q <= total_q + bit_count_t'(popcount(ctrl.chan_sel));
            end
        end
    end

    assign err_count_o   = err_q;
    assign total_count_o = total_q;

endmodule

`default_nettype wire

//--- design/rx_dcore_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_macros.svh"

module rx_dcore_top (
    input  wire logic               clk_adc,
    input  wire logic               rst_i,
    input  wire rx_pkg::adc_mag_t   adc_mag_i [`NTI-1:0],
    input  wire rx_pkg::lane_bits_t adc_sign_i,
    input  wire rx_pkg::lane_bits_t chan_sel_i,
    input  wire rx_pkg::lane_bits_t inv_chicken_i,
    input  wire rx_pkg::adc_code_t  pfd_offset_i,
    input  wire rx_pkg::adc_code_t  adc_thresh_i,
    input  wire logic               sel_bist_i,
    input  wire logic               gen_inj_err_i,
    input  wire logic               prbs_cke_i,
    output rx_pkg::bit_count_t      err_count_o,
    output rx_pkg::bit_count_t      total_count_o
);
    import rx_pkg::*;

    prbs_ctrl_if ctrl_if ();

    adc_code_t  adc_code [`NTI-1:0];
    lane_bits_t bist_bits;
    lane_bits_t rx_bits;

    // prbs test configuration
    assign ctrl_if.sel_bist    = sel_bist_i;
    assign ctrl_if.gen_inj_err = gen_inj_err_i;
    assign ctrl_if.prbs_cke    = prbs_cke_i;
    assign ctrl_if.chan_sel    = chan_sel_i;
    assign ctrl_if.inv_chicken = inv_chicken_i;

    adc_unfolder unfold_i (
        .clk_adc      (clk_adc),
        .rst_i        (rst_i),
        .adc_mag_i    (adc_mag_i),
        .adc_sign_i   (adc_sign_i),
        .pfd_offset_i (pfd_offset_i),
        .code_o       (adc_code)
    );

    prbs_bist_gen bist_gen_i (
        .clk_adc (clk_adc),
        .rst_i   (rst_i),
        .ctrl    (ctrl_if),
        .bits_o  (bist_bits)
    );

    // slicer plus adc/bist source select
    bit_decision decision_i (
        .clk_adc     (clk_adc),
        .rst_i       (rst_i),
        .code_i      (adc_code),
        .thresh_i    (adc_thresh_i),
        .bist_bits_i (bist_bits),
        .ctrl        (ctrl_if),
        .rx_bits_o   (rx_bits)
    );

    prbs_err_checker checker_i (
        .clk_adc       (clk_adc),
        .rst_i         (rst_i),
        .rx_bits_i     (rx_bits),
        .ctrl          (ctrl_if),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

endmodule

`default_nettype wire

//--- verif/rx_dcore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rx_macros.svh"

module rx_dcore_tb;
    import rx_pkg::*;

    localparam int max_rows  = 10;
    localparam int no_flip   = -1;
    localparam int flip_lane = 5;
    localparam int mag_level = 12;

    logic       clk_adc = 1'b0;
    logic       rst;
    adc_mag_t   adc_mag [`NTI-1:0];
    lane_bits_t adc_sign;
    lane_bits_t chan_sel;
    lane_bits_t inv_chicken;
    adc_code_t  pfd_offset;
    adc_code_t  adc_thresh;
    logic       sel_bist;
    logic       gen_inj_err;
    logic       prbs_cke;
    bit_count_t err_count;
    bit_count_t total_count;

    // stimulus and expected errors per test
    string      row_name [max_rows];
    bit         row_bist [max_rows];
    lane_bits_t row_sel [max_rows];
    lane_bits_t row_inv [max_rows];
    adc_code_t  row_offset [max_rows];
    adc_code_t  row_thresh [max_rows];
    bit         row_inv_pol [max_rows];
    int         row_flip [max_rows];
    int         row_words [max_rows];
    int         row_exp_err [max_rows];
    bit         row_err_all [max_rows];
    int         row_count = 0;
    bit         table_ready = 1'b0;

    int         error_count = 0;
    // reference prbs7 history with bit 0 seven bits back
    prbs_hist_t ref_hist;

    rx_dcore_top UUT (
        .clk_adc       (clk_adc),
        .rst_i         (rst),
        .adc_mag_i     (adc_mag),
        .adc_sign_i    (adc_sign),
        .chan_sel_i    (chan_sel),
        .inv_chicken_i (inv_chicken),
        .pfd_offset_i  (pfd_offset),
        .adc_thresh_i  (adc_thresh),
        .sel_bist_i    (sel_bist),
        .gen_inj_err_i (gen_inj_err),
        .prbs_cke_i    (prbs_cke),
        .err_count_o   (err_count),
        .total_count_o (total_count)
    );

    always #2 clk_adc = ~clk_adc;

    task automatic add_row(input string name, input bit bist, input lane_bits_t sel,
                           input lane_bits_t inv, input adc_code_t offset,
                           input adc_code_t thresh, input bit inv_pol, input int flip,
                           input int words, input int exp_err, input bit err_all);
        row_name[row_count]    = name;
        row_bist[row_count]    = bist;
        row_sel[row_count]     = sel;
        row_inv[row_count]     = inv;
        row_offset[row_count]  = offset;
        row_thresh[row_count]  = thresh;
        row_inv_pol[row_count] = inv_pol;
        row_flip[row_count]    = flip;
        row_words[row_count]   = words;
        row_exp_err[row_count] = exp_err;
        row_err_all[row_count] = err_all;
        row_count++;
    endtask

    task automatic load_table();
        add_row("adc_clean",    0, 16'hffff, 16'h0000, 0,   0, 0, no_flip, 20, 0, 0);
        add_row("adc_flip",     0, 16'hffff, 16'h0000, 0,   0, 0, 9,       20, 3, 0);
        add_row("adc_inverted", 0, 16'hffff, 16'hffff, 0,   0, 1, no_flip, 20, 0, 0);
        add_row("adc_offset",   0, 16'hffff, 16'h0000, -15, 0, 0, no_flip, 20, 0, 1);
        add_row("thresh_low",   0, 16'hffff, 16'h0000, 0,   -13, 0, no_flip, 20, 0, 1);
        add_row("thresh_equal", 0, 16'hffff, 16'h0000, 0,   -12, 0, no_flip, 20, 0, 0);
        add_row("adc_half_sel", 0, 16'h00ff, 16'h0000, 0,   0, 0, no_flip, 24, 0, 0);
        add_row("bist_inject",  1, 16'hffff, 16'h0000, 0,   0, 0, 7,       20, 3, 0);
        add_row("bist_masked",  1, 16'h0000, 16'h0000, 0,   0, 0, 7,       20, 0, 0);
    endtask

    // b[n] = b[n-7] ^ b[n-6] one bit at a time from the oldest lane
    task automatic next_ref_word(output lane_bits_t w);
        logic b;
        for (int k = 0; k < `NTI; k++) begin
            b = ref_hist[0] ^ ref_hist[1];
            ref_hist = {b, ref_hist[`NPRBS-1:1]};
            w[k] = b;
        end
    endtask

    task automatic check(input string name, input string what,
                         input longint expected, input longint actual);
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic run_row(input int r);
        lane_bits_t w;
        longint     exp_total;
        longint     exp_err;
        rst         = 1'b1;
        prbs_cke    = 1'b0;
        gen_inj_err = 1'b0;
        sel_bist    = row_bist[r];
        chan_sel    = row_sel[r];
        inv_chicken = row_inv[r];
        pfd_offset  = row_offset[r];
        adc_thresh  = row_thresh[r];
        adc_sign    = '0;
        repeat (16) begin
            @(posedge clk_adc);
            #1;
        end
        rst      = 1'b0;
        ref_hist = '1;
        // adc words reach the checker two cycles after they are driven and bist words one cycle after
        for (int t = 0; t < row_words[r] + 6; t++) begin
            if (!row_bist[r] && t < row_words[r]) begin
                next_ref_word(w);
                if (t == row_flip[r]) begin
                    w[flip_lane] = ~w[flip_lane];
                end
                adc_sign = row_inv_pol[r] ? ~w : w;
            end
            gen_inj_err = row_bist[r] && (t == row_flip[r] + 1);
            prbs_cke    = (t >= 2) && (t < row_words[r] + 2);
            @(posedge clk_adc);
            #1;
        end
        // first enabled word only primes the checker
        exp_total = longint'(row_words[r] - 1) * $countones(row_sel[r]);
        exp_err   = row_err_all[r] ? exp_total : longint'(row_exp_err[r]);
        check(row_name[r], "total_count", exp_total, longint'(total_count));
        check(row_name[r], "err_count", exp_err, longint'(err_count));
    endtask

    initial begin : watchdog
        longint limit_ns;
        wait (table_ready);
        limit_ns = 0;
        for (int r = 0; r < row_count; r++) begin
            limit_ns += row_words[r] + 24;
        end
        limit_ns = limit_ns * 4 * 2;
        #(limit_ns);
        $display("timeout: the run did not complete within %0d ns", limit_ns);
        $display("test failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        adc_sign    = '0;
        chan_sel    = '0;
        inv_chicken = '0;
        pfd_offset  = '0;
        adc_thresh  = '0;
        sel_bist    = 1'b0;
        gen_inj_err = 1'b0;
        prbs_cke    = 1'b0;
        for (int k = 0; k < `NTI; k++) begin
            adc_mag[k] = adc_mag_t'(mag_level);
        end
        load_table();
        table_ready = 1'b1;
        for (int r = 0; r < row_count; r++) begin
            run_row(r);
        end
        $display("summary: %0d rows run, %0d errors", row_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rx_dcore.f
+incdir+include
design/rx_pkg.sv
design/prbs_ctrl_if.sv
design/adc_unfolder.sv
design/bit_decision.sv
design/prbs_bist_gen.sv
design/prbs_err_checker.sv
design/rx_dcore_top.sv
verif/rx_dcore_tb.sv

//--- Bender.yml
package:
  name: rx_dcore

export_include_dirs:
  - include

sources:
  - files:
      - design/rx_pkg.sv
      - design/prbs_ctrl_if.sv
      - design/adc_unfolder.sv
      - design/bit_decision.sv
      - design/prbs_bist_gen.sv
      - design/prbs_err_checker.sv
      - design/rx_dcore_top.sv
  - target: test
    files:
      - verif/rx_dcore_tb.sv
